//--- design/lsu_pkg.sv
package lsu_pkg;

    localparam int tag_w     = 4;
    localparam int entry_num = 2 ** tag_w;

    typedef logic [tag_w-1:0] tag_t;
    typedef logic [31:0]      data_t;
    typedef logic [31:0]      addr_t;
    typedef logic [11:0]      imm_t;

    typedef enum logic [3:0] {
        op_none,
        op_lb,
        op_lh,
        op_lw,
        op_lbu,
        op_lhu,
        op_sb,
        op_sh,
        op_sw
    } mem_op_e;

    typedef enum logic [1:0] {
        size_byte,
        size_half,
        size_word
    } size_e;

    typedef struct packed {
        logic    valid;
        mem_op_e op;
        imm_t    imm;
        tag_t    rd_tag;
        tag_t    rs1_tag;
        data_t   rs1_data;
        tag_t    rs2_tag;
        data_t   rs2_data;
    } dispatch_s;

    typedef struct packed {
        logic  valid;
        logic  is_store;
        size_e size;
        logic  sign_ext;
        imm_t  imm;
        tag_t  rd_tag;
        tag_t  rs1_tag;
        logic  rs1_ready;
        data_t rs1_data;
        tag_t  rs2_tag;
        logic  rs2_ready;
        data_t rs2_data;
    } lsb_entry_s;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        data_t data;
    } bcast_s;

    typedef struct packed {
        logic  valid;
        logic  is_store;
        size_e size;
        logic  sign_ext;
        tag_t  tag;
        addr_t addr;
        data_t wdata;
    } mem_req_s;

    // tag 0 never matches, it stands for a ready value
    function automatic logic bcast_hit(bcast_s b, tag_t t);
        return b.valid && (b.tag == t) && (t != '0);
    endfunction

    // capture waiting operands from either broadcast
    function automatic lsb_entry_s wake_entry(lsb_entry_s e, bcast_s a, bcast_s b);
        lsb_entry_s w;
        w = e;
        if (!e.rs1_ready) begin
            if (bcast_hit(a, e.rs1_tag)) begin
                w.rs1_ready = 1'b1;
                w.rs1_data  = a.data;
            end else if (bcast_hit(b, e.rs1_tag)) begin
                w.rs1_ready = 1'b1;
                w.rs1_data  = b.data;
            end
        end
        if (!e.rs2_ready) begin
            if (bcast_hit(a, e.rs2_tag)) begin
                w.rs2_ready = 1'b1;
                w.rs2_data  = a.data;
            end else if (bcast_hit(b, e.rs2_tag)) begin
                w.rs2_ready = 1'b1;
                w.rs2_data  = b.data;
            end
        end
        return w;
    endfunction

endpackage

//--- design/lsu_dispatch_decode.sv
`timescale 1ns/1ps

module lsu_dispatch_decode (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                rdy,
    input  logic                clr,
    input  lsu_pkg::dispatch_s  dispatch,
    input  lsu_pkg::bcast_s     ex_bcast,
    input  lsu_pkg::bcast_s     res_bcast,
    output lsu_pkg::lsb_entry_s entry_in
);

    logic                is_mem;
    lsu_pkg::lsb_entry_s decoded;

    always_comb begin
        decoded  = '0;
        is_mem   = 1'b1;
        case (dispatch.op)
            lsu_pkg::op_lb: begin
                decoded.size     = lsu_pkg::size_byte;
                decoded.sign_ext = 1'b1;
            end
            lsu_pkg::op_lh: begin
                decoded.size     = lsu_pkg::size_half;
                decoded.sign_ext = 1'b1;
            end
            lsu_pkg::op_lw:  decoded.size = lsu_pkg::size_word;
            lsu_pkg::op_lbu: decoded.size = lsu_pkg::size_byte;
            lsu_pkg::op_lhu: decoded.size = lsu_pkg::size_half;
            lsu_pkg::op_sb: begin
                decoded.size     = lsu_pkg::size_byte;
                decoded.is_store = 1'b1;
            end
            lsu_pkg::op_sh: begin
                decoded.size     = lsu_pkg::size_half;
                decoded.is_store = 1'b1;
            end
            lsu_pkg::op_sw: begin
                decoded.size     = lsu_pkg::size_word;
                decoded.is_store = 1'b1;
            end
            default: is_mem = 1'b0;
        endcase

        decoded.valid     = dispatch.valid && is_mem;
        decoded.imm       = dispatch.imm;
        decoded.rd_tag    = dispatch.rd_tag;
        decoded.rs1_tag   = dispatch.rs1_tag;
        decoded.rs1_ready = (dispatch.rs1_tag == '0);
        decoded.rs1_data  = dispatch.rs1_data;
        decoded.rs2_tag   = dispatch.rs2_tag;
        decoded.rs2_ready = (dispatch.rs2_tag == '0);
        decoded.rs2_data  = dispatch.rs2_data;

        // producer may broadcast in the dispatch cycle itself
        decoded = lsu_pkg::wake_entry(decoded, ex_bcast, res_bcast);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_in <= '0;
        end else if (clr) begin
            entry_in.valid <= 1'b0;
        end else if (rdy) begin
            entry_in <= decoded;
        end
    end

endmodule

//--- design/load_store_buffer.sv
`timescale 1ns/1ps

module load_store_buffer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                rdy,
    input  logic                clr,
    input  lsu_pkg::lsb_entry_s entry_in,
    input  lsu_pkg::bcast_s     ex_bcast,
    input  lsu_pkg::bcast_s     res_bcast,
    input  logic                commit_valid,
    input  lsu_pkg::tag_t       commit_tag,
    output lsu_pkg::mem_req_s   mem_req,
    output logic                full
);

    // one slot per tag, slot 0 stays empty
    lsu_pkg::lsb_entry_s entries [lsu_pkg::entry_num];
    logic [lsu_pkg::entry_num-1:1] issued;
    logic [lsu_pkg::entry_num-1:1] occ;

    lsu_pkg::lsb_entry_s entry_woken;
    lsu_pkg::lsb_entry_s commit_entry;
    lsu_pkg::lsb_entry_s sel_entry;
    lsu_pkg::tag_t       ld_pick;
    lsu_pkg::tag_t       sel_tag;
    lsu_pkg::addr_t      sel_addr;
    lsu_pkg::mem_req_s   req_next;
    logic                ld_go;
    logic                st_go;

    always_comb begin
        for (int i = 1; i < lsu_pkg::entry_num; i++) begin
            occ[i] = entries[i].valid;
        end
    end

    assign full = rdy && (&occ);

    // incoming entry also sees this cycle's broadcasts
    assign entry_woken = lsu_pkg::wake_entry(entry_in, ex_bcast, res_bcast);

    assign commit_entry = entries[commit_tag];
    assign st_go = commit_valid && commit_entry.valid && commit_entry.is_store
                   && commit_entry.rs1_ready && commit_entry.rs2_ready;

    // lowest ready load wins, so scan downward
    always_comb begin
        ld_go   = 1'b0;
        ld_pick = '0;
        for (int i = lsu_pkg::entry_num - 1; i >= 1; i--) begin
            if (entries[i].valid && !entries[i].is_store && entries[i].rs1_ready
                && !issued[i]) begin
                ld_go   = 1'b1;
                ld_pick = lsu_pkg::tag_t'(i);
            end
        end
    end

    always_comb begin
        sel_tag   = st_go ? commit_tag : ld_pick;
        sel_entry = entries[sel_tag];
        sel_addr  = sel_entry.rs1_data + {{20{sel_entry.imm[11]}}, sel_entry.imm};

        req_next.valid    = st_go || ld_go;
        req_next.is_store = st_go;
        req_next.size     = sel_entry.size;
        req_next.sign_ext = sel_entry.sign_ext;
        req_next.tag      = sel_tag;
        req_next.addr     = sel_addr;
        req_next.wdata    = sel_entry.rs2_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < lsu_pkg::entry_num; i++) begin
                entries[i].valid <= 1'b0;
            end
            issued  <= '0;
            mem_req <= '0;
        end else if (clr) begin
            for (int i = 0; i < lsu_pkg::entry_num; i++) begin
                entries[i].valid <= 1'b0;
            end
            issued        <= '0;
            mem_req.valid <= 1'b0;
        end else if (rdy) begin
            // operand wakeup
            for (int i = 1; i < lsu_pkg::entry_num; i++) begin
                if (entries[i].valid) begin
                    entries[i] <= lsu_pkg::wake_entry(entries[i], ex_bcast, res_bcast);
                end
            end

            mem_req <= req_next;
            if (st_go) begin
                entries[commit_tag].valid <= 1'b0;
            end else if (ld_go) begin
                issued[ld_pick] <= 1'b1;
            end

            // load is done once its data comes back
            if (res_bcast.valid) begin
                entries[res_bcast.tag].valid <= 1'b0;
                issued[res_bcast.tag]        <= 1'b0;
            end

            if (entry_in.valid) begin
                entries[entry_in.rd_tag] <= entry_woken;
                issued[entry_in.rd_tag]  <= 1'b0;
            end
        end
    end

endmodule

//--- design/lsu_data_mem.sv
`timescale 1ns/1ps

module lsu_data_mem #(
    parameter int mem_words = 256
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              rdy,
    input  lsu_pkg::mem_req_s mem_req,
    output lsu_pkg::bcast_s   mem_rsp
);

    localparam int idx_w = $clog2(mem_words);

    lsu_pkg::data_t mem [mem_words];

    logic [idx_w-1:0] word_idx;
    logic [3:0]       byte_en;
    lsu_pkg::data_t   wlanes;
    lsu_pkg::data_t   rd_word;
    lsu_pkg::data_t   rd_ext;
    logic [7:0]       rd_byte;
    logic [15:0]      rd_half;

    assign word_idx = mem_req.addr[idx_w+1:2];
    assign rd_word  = mem[word_idx];

    // lane enables and replicated write data
    always_comb begin
        case (mem_req.size)
            lsu_pkg::size_byte: begin
                byte_en = 4'b0001 << mem_req.addr[1:0];
                wlanes  = {4{mem_req.wdata[7:0]}};
            end
            lsu_pkg::size_half: begin
                byte_en = mem_req.addr[1] ? 4'b1100 : 4'b0011;
                wlanes  = {2{mem_req.wdata[15:0]}};
            end
            default: begin
                byte_en = 4'b1111;
                wlanes  = mem_req.wdata;
            end
        endcase
    end

    always_comb begin
        rd_byte = rd_word[8*mem_req.addr[1:0] +: 8];
        rd_half = mem_req.addr[1] ? rd_word[31:16] : rd_word[15:0];
        case (mem_req.size)
            lsu_pkg::size_byte: rd_ext = {{24{mem_req.sign_ext & rd_byte[7]}}, rd_byte};
            lsu_pkg::size_half: rd_ext = {{16{mem_req.sign_ext & rd_half[15]}}, rd_half};
            default:            rd_ext = rd_word;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rdy && mem_req.valid && mem_req.is_store) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    mem[word_idx][8*b +: 8] <= wlanes[8*b +: 8];
                end
            end
        end
    end

    // stores complete silently
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_rsp <= '0;
        end else if (rdy) begin
            mem_rsp.valid <= mem_req.valid && !mem_req.is_store;
            mem_rsp.tag   <= mem_req.tag;
            mem_rsp.data  <= rd_ext;
        end
    end

endmodule

//--- design/lsu_top.sv
`timescale 1ns/1ps

module lsu_top #(
    parameter int mem_words = 256
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               rdy,
    input  logic               clr,
    input  lsu_pkg::dispatch_s dispatch,
    input  lsu_pkg::bcast_s    ex_bcast,
    input  logic               commit_valid,
    input  lsu_pkg::tag_t      commit_tag,
    output lsu_pkg::bcast_s    result,
    output logic               full
);

    lsu_pkg::lsb_entry_s entry_in;
    lsu_pkg::mem_req_s   mem_req;

    lsu_dispatch_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .rdy       (rdy),
        .clr       (clr),
        .dispatch  (dispatch),
        .ex_bcast  (ex_bcast),
        .res_bcast (result),
        .entry_in  (entry_in)
    );

    // load results double as the second wakeup source
    load_store_buffer u_lsb (
        .clk          (clk),
        .rst_n        (rst_n),
        .rdy          (rdy),
        .clr          (clr),
        .entry_in     (entry_in),
        .ex_bcast     (ex_bcast),
        .res_bcast    (result),
        .commit_valid (commit_valid),
        .commit_tag   (commit_tag),
        .mem_req      (mem_req),
        .full         (full)
    );

    lsu_data_mem #(
        .mem_words (mem_words)
    ) u_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .rdy     (rdy),
        .mem_req (mem_req),
        .mem_rsp (result)
    );

endmodule

//--- tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // three cycles of reset, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

//--- tests/lsu_assertions.sv
`timescale 1ns/1ps

module lsu_assertions (
    input logic                clk,
    input logic                rst_n,
    input logic                rdy,
    input logic                clr,
    input logic                full,
    input lsu_pkg::lsb_entry_s entry_in,
    input logic                commit_valid,
    input lsu_pkg::lsb_entry_s commit_entry,
    input lsu_pkg::mem_req_s   mem_req
);

    int fail_count = 0;

    // dispatcher holds off while every slot is taken
    no_dispatch_when_full: assert property (
        @(posedge clk) disable iff (!rst_n || clr)
        full |=> !entry_in.valid
    ) else begin
        fail_count++;
        $error("an entry arrived although the buffer was full");
    end

    commit_hits_ready_store: assert property (
        @(posedge clk) disable iff (!rst_n)
        (rdy && commit_valid) |-> (commit_entry.valid && commit_entry.is_store
                                   && commit_entry.rs1_ready && commit_entry.rs2_ready)
    ) else begin
        fail_count++;
        $error("commit did not hit an occupied store with ready operands");
    end

    req_idle_after_reset: assert property (
        @(posedge clk) !rst_n |=> !mem_req.valid
    ) else begin
        fail_count++;
        $error("memory request valid right after reset");
    end

endmodule

bind load_store_buffer lsu_assertions u_chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .rdy          (rdy),
    .clr          (clr),
    .full         (full),
    .entry_in     (entry_in),
    .commit_valid (commit_valid),
    .commit_entry (commit_entry),
    .mem_req      (mem_req)
);

//--- tests/tb_lsu.sv
`timescale 1ns/1ps

module tb_lsu;

    localparam int clk_period   = 40;
    localparam int reset_cycles = 4;
    localparam int rsp_bound    = 10;
    // cycle budget of each test
    localparam int t_round_trip = 30;
    localparam int t_sub_word   = 150;
    localparam int t_wakeup     = 40;
    localparam int t_feedback   = 40;
    localparam int t_full_flush = 50;
    localparam int t_stall      = 40;
    localparam int watchdog_cycles = reset_cycles + t_round_trip + t_sub_word + t_wakeup
                                     + t_feedback + t_full_flush + t_stall;

    logic               clk;
    logic               rst_n;
    logic               rdy;
    logic               clr;
    lsu_pkg::dispatch_s dispatch;
    lsu_pkg::bcast_s    ex_bcast;
    logic               commit_valid;
    lsu_pkg::tag_t      commit_tag;
    lsu_pkg::bcast_s    result;
    logic               full;
    lsu_pkg::data_t     rng_state;

    tb_clock_gen clock0 (
        .clk   (clk),
        .rst_n (rst_n)
    );

    lsu_top #(
        .mem_words (256)
    ) dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .rdy          (rdy),
        .clr          (clr),
        .dispatch     (dispatch),
        .ex_bcast     (ex_bcast),
        .commit_valid (commit_valid),
        .commit_tag   (commit_tag),
        .result       (result),
        .full         (full)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_result(input string name, input lsu_pkg::tag_t exp_tag,
            input lsu_pkg::data_t exp_data, input lsu_pkg::tag_t act_tag,
            input lsu_pkg::data_t act_data);
        if (act_tag !== exp_tag || act_data !== exp_data) begin
            fail_run($sformatf("FAILED %s: expected tag %0d data %h, actual tag %0d data %h",
                               name, exp_tag, exp_data, act_tag, act_data));
        end
    endtask

    task automatic compare_full(input string name, input logic exp_full, input logic act_full);
        if (act_full !== exp_full) begin
            fail_run($sformatf("FAILED %s: expected full %b, actual full %b",
                               name, exp_full, act_full));
        end
    endtask

    function automatic lsu_pkg::data_t xorshift(input lsu_pkg::data_t x);
        lsu_pkg::data_t s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic next_rand(output lsu_pkg::data_t v);
        rng_state = xorshift(rng_state);
        v = rng_state;
    endtask

    // lane picked by byte offset, then widened to 32 bits
    function automatic lsu_pkg::data_t lane_value(input lsu_pkg::data_t word, input int off,
            input int nbytes, input logic signed_ld);
        lsu_pkg::data_t v;
        v = word >> (8 * off);
        if (nbytes == 1) begin
            v = signed_ld ? {{24{v[7]}}, v[7:0]} : {24'h0, v[7:0]};
        end else begin
            v = signed_ld ? {{16{v[15]}}, v[15:0]} : {16'h0, v[15:0]};
        end
        return v;
    endfunction

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic dispatch_op(input lsu_pkg::mem_op_e op, input lsu_pkg::tag_t rd,
            input lsu_pkg::tag_t rs1_tag, input lsu_pkg::data_t rs1_data,
            input lsu_pkg::tag_t rs2_tag, input lsu_pkg::data_t rs2_data,
            input lsu_pkg::imm_t imm);
        dispatch.valid    = 1'b1;
        dispatch.op       = op;
        dispatch.imm      = imm;
        dispatch.rd_tag   = rd;
        dispatch.rs1_tag  = rs1_tag;
        dispatch.rs1_data = rs1_data;
        dispatch.rs2_tag  = rs2_tag;
        dispatch.rs2_data = rs2_data;
        @(negedge clk);
        dispatch.valid = 1'b0;
    endtask

    task automatic commit_store(input lsu_pkg::tag_t tag);
        commit_valid = 1'b1;
        commit_tag   = tag;
        @(negedge clk);
        commit_valid = 1'b0;
    endtask

    task automatic broadcast_ex(input lsu_pkg::tag_t tag, input lsu_pkg::data_t data);
        ex_bcast.valid = 1'b1;
        ex_bcast.tag   = tag;
        ex_bcast.data  = data;
        @(negedge clk);
        ex_bcast.valid = 1'b0;
    endtask

    // one idle cycle lets the entry land before the commit
    task automatic store_word(input lsu_pkg::tag_t tag, input lsu_pkg::addr_t addr,
            input lsu_pkg::data_t data);
        dispatch_op(lsu_pkg::op_sw, tag, '0, addr, '0, data, '0);
        idle(1);
        commit_store(tag);
    endtask

    task automatic wait_result(input string name, input lsu_pkg::tag_t tag,
            input lsu_pkg::data_t data);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!result.valid && waited < rsp_bound) begin
            waited++;
            @(negedge clk);
        end
        if (!result.valid) begin
            fail_run($sformatf("%s: no result for tag %0d within %0d cycles",
                               name, tag, rsp_bound));
        end else begin
            compare_result(name, tag, data, result.tag, result.data);
        end
    endtask

    task automatic expect_quiet(input string name, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            if (result.valid) begin
                fail_run($sformatf("%s: a result for tag %0d came out when none was due",
                                   name, result.tag));
            end
        end
    endtask

    task automatic load_and_check(input string name, input lsu_pkg::mem_op_e op,
            input lsu_pkg::tag_t tag, input lsu_pkg::addr_t base, input lsu_pkg::imm_t imm,
            input lsu_pkg::data_t exp_data);
        dispatch_op(op, tag, '0, base, '0, '0, imm);
        wait_result(name, tag, exp_data);
    endtask

    task automatic word_round_trip();
        lsu_pkg::data_t v;
        next_rand(v);
        store_word(4'd1, 32'h0000_0110, v);
        load_and_check("word_round_trip", lsu_pkg::op_lw, 4'd2, 32'h0000_0100, 12'h010, v);
    endtask

    task automatic sub_word_loads();
        lsu_pkg::data_t w;
        lsu_pkg::imm_t  off;
        next_rand(w);
        // byte 0 and byte 3 negative, bytes 1 and 2 positive
        w = (w | 32'h8000_0080) & 32'hff7f_7fff;
        store_word(4'd3, 32'h0000_0200, w);
        for (int i = 0; i < 4; i++) begin
            off = lsu_pkg::imm_t'(i);
            load_and_check("sub_word_loads lb", lsu_pkg::op_lb, 4'd4, 32'h0000_0200, off,
                           lane_value(w, i, 1, 1'b1));
            load_and_check("sub_word_loads lbu", lsu_pkg::op_lbu, 4'd4, 32'h0000_0200, off,
                           lane_value(w, i, 1, 1'b0));
            if (i % 2 == 0) begin
                load_and_check("sub_word_loads lh", lsu_pkg::op_lh, 4'd4, 32'h0000_0200,
                               off, lane_value(w, i, 2, 1'b1));
                load_and_check("sub_word_loads lhu", lsu_pkg::op_lhu, 4'd4, 32'h0000_0200,
                               off, lane_value(w, i, 2, 1'b0));
            end
        end
    endtask

    task automatic base_wakeup();
        lsu_pkg::data_t v;
        lsu_pkg::data_t junk;
        next_rand(v);
        next_rand(junk);
        store_word(4'd6, 32'h0000_0300, v);
        // -8 from the broadcast base lands on the stored word
        dispatch_op(lsu_pkg::op_lw, 4'd5, 4'd9, junk, '0, '0, 12'hff8);
        expect_quiet("base_wakeup", 6);
        broadcast_ex(4'd9, 32'h0000_0308);
        wait_result("base_wakeup", 4'd5, v);
    endtask

    task automatic result_feedback();
        lsu_pkg::data_t v;
        next_rand(v);
        store_word(4'd7, 32'h0000_0400, v);
        dispatch_op(lsu_pkg::op_lw, 4'd8, '0, 32'h0000_0400, '0, '0, '0);
        dispatch_op(lsu_pkg::op_sw, 4'd10, '0, 32'h0000_0404, 4'd8, '0, '0);
        wait_result("result_feedback", 4'd8, v);
        idle(1);
        commit_store(4'd10);
        load_and_check("result_feedback", lsu_pkg::op_lw, 4'd11, 32'h0000_0404, '0, v);
    endtask

    task automatic full_and_flush();
        // every base waits on another queued load
        for (int i = 1; i < lsu_pkg::entry_num; i++) begin
            dispatch_op(lsu_pkg::op_lw, lsu_pkg::tag_t'(i), lsu_pkg::tag_t'(i % 15 + 1),
                        '0, '0, '0, '0);
        end
        idle(2);
        compare_full("full_and_flush", 1'b1, full);
        // a stalled buffer reads not full
        rdy = 1'b0;
        @(negedge clk);
        compare_full("full_and_flush stalled", 1'b0, full);
        rdy = 1'b1;
        @(negedge clk);
        compare_full("full_and_flush", 1'b1, full);
        clr = 1'b1;
        @(negedge clk);
        clr = 1'b0;
        compare_full("full_and_flush", 1'b0, full);
        // entry 1 would wake on tag 2 had it survived
        broadcast_ex(4'd2, 32'h0000_0100);
        expect_quiet("full_and_flush", 12);
    endtask

    task automatic stall_hold();
        lsu_pkg::data_t v;
        next_rand(v);
        store_word(4'd12, 32'h0000_0500, v);
        dispatch_op(lsu_pkg::op_lw, 4'd13, '0, 32'h0000_0500, '0, '0, '0);
        rdy = 1'b0;
        expect_quiet("stall_hold", 8);
        rdy = 1'b1;
        wait_result("stall_hold", 4'd13, v);
    endtask

    initial begin
        #(watchdog_cycles * clk_period);
        fail_run($sformatf("watchdog expired after %0d cycles before the tests finished",
                           watchdog_cycles));
    end

    initial begin
        rng_state    = 32'hbf9c628d;
        rdy          = 1'b1;
        clr          = 1'b0;
        dispatch     = '0;
        ex_bcast     = '0;
        commit_valid = 1'b0;
        commit_tag   = '0;
        wait (rst_n === 1'b1);
        @(negedge clk);
        word_round_trip();
        sub_word_loads();
        base_wakeup();
        result_feedback();
        full_and_flush();
        stall_hold();
        idle(2);
        if (dut0.u_lsb.u_chk.fail_count == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            fail_run("an assertion bound into the load/store buffer failed");
        end
    end

endmodule

//--- verilog.f
design/lsu_pkg.sv
design/lsu_dispatch_decode.sv
design/load_store_buffer.sv
design/lsu_data_mem.sv
design/lsu_top.sv
tests/tb_clock_gen.sv
tests/lsu_assertions.sv
tests/tb_lsu.sv
